// ==== list.f ====
common/rca_cfg_pkg.sv
common/rca_op_pkg.sv
rca_config/cfg_bank.sv
rca_config/rca_config_regs.sv
rtl/rca_issue_decode.sv
rtl/rca_grid.sv
rtl/rca_writeback.sv
rtl/rca_unit.sv
dv/tb_rca_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := tb_rca_unit
FILE_LIST := list.f
BUILD_DIR := obj_dir

.PHONY: test clean help

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/tb_rca_unit.sv ====
`timescale 1ns/100ps

module tb_rca_unit;
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;

    localparam int clk_half       = 4;
    localparam int clk_period     = 2 * clk_half;
    localparam int num_rounds     = 16;
    localparam int cfg_per_set    = 2 * grid_num_rows + num_write_ports + 1;
    localparam int total_requests = 7 + num_rounds * (2 * cfg_per_set + 8)
                                  + 2 * num_rcas * reg_tbl_entries + 2 * num_rcas;
    localparam int margin_cycles  = 64;

    typedef logic [num_write_ports-1:0][xlen-1:0] word_vec_t;

    logic       clk;
    logic       arst_n;
    logic       new_request;
    id_t        id;
    rca_instr_e kind;
    rca_sel_t   rca_sel;
    logic       use_fb;
    cfg_addr_t  cfg_addr;
    cfg_data_t  cfg_data;
    operand_t   rs             [num_read_ports];
    logic       wb_done;
    id_t        wb_id;
    operand_t   wb_rd          [num_write_ports];
    reg_addr_t  src_reg_addrs  [num_read_ports];
    reg_addr_t  dest_reg_addrs [num_write_ports];

    // Model of every table, all sets.
    reg_addr_t  m_fb      [num_rcas][reg_tbl_entries];
    reg_addr_t  m_nfb     [num_rcas][reg_tbl_entries];
    row_op_e    m_row_op  [num_rcas][grid_num_rows];
    io_sel_t    m_io_sel  [num_rcas][grid_num_rows];
    row_sel_t   m_res_sel [num_rcas][num_write_ports];
    io_use_t    m_io_use  [num_rcas];

    id_t         exp_id [$];
    word_vec_t   exp_rd [$];
    id_t         next_id;
    logic [31:0] lfsr_state;

    rca_unit u_rca_unit (
        .clk(clk), .arst_n(arst_n), .new_request(new_request), .id(id), .kind(kind),
        .rca_sel(rca_sel), .use_fb(use_fb), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .rs(rs), .wb_done(wb_done), .wb_id(wb_id), .wb_rd(wb_rd),
        .src_reg_addrs(src_reg_addrs), .dest_reg_addrs(dest_reg_addrs)
    );

    always #(clk_half) clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[30:0], lfsr_state[0]};   // Output bit of this step.
            lfsr_state = lfsr_step(lfsr_state);
        end
        return val;
    endfunction

    function automatic word_vec_t random_ops();
        word_vec_t ops;
        for (int p = 0; p < num_read_ports; p++) begin
            ops[p] = random_bits(xlen);
        end
        return ops;
    endfunction

    // Expected results of a use on set sel.
    function automatic word_vec_t grid_ref(input int sel, input word_vec_t ops);
        logic [xlen-1:0] val [grid_num_rows];
        logic [xlen-1:0] prev;
        logic [xlen-1:0] opnd;
        word_vec_t       res;
        for (int r = 0; r < grid_num_rows; r++) begin
            if (r == 0) prev = '0;
            else prev = val[r-1];
            if (m_io_use[sel][r] && (int'(m_io_sel[sel][r]) < num_read_ports)) begin
                opnd = ops[m_io_sel[sel][r]];
            end else begin
                opnd = '0;   // Unused row or select past port 4.
            end
            case (m_row_op[sel][r])
                row_pass: val[r] = opnd;
                row_add:  val[r] = prev + opnd;
                row_xor:  val[r] = prev ^ opnd;
                default:  val[r] = prev - opnd;
            endcase
        end
        for (int w = 0; w < num_write_ports; w++) begin
            res[w] = val[m_res_sel[sel][w]];
        end
        return res;
    endfunction

    task automatic stop_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic idle();
        @(negedge clk);
        new_request = 1'b0;
    endtask

    task automatic issue(input rca_instr_e k, input int sel, input logic fb,
                         input int addr, input logic [7:0] data, input word_vec_t ops);
        @(negedge clk);
        new_request = 1'b1;
        id          = next_id;
        kind        = k;
        rca_sel     = rca_sel_t'(sel);
        use_fb      = fb;
        cfg_addr    = cfg_addr_t'(addr);
        cfg_data    = data;
        for (int p = 0; p < num_read_ports; p++) begin
            rs[p] = ops[p];
        end
        case (k)
            rca_cfg_fb_reg:     m_fb[sel][addr]      = reg_addr_t'(data);
            rca_cfg_nfb_reg:    m_nfb[sel][addr]     = reg_addr_t'(data);
            rca_cfg_row_op:     m_row_op[sel][addr]  = row_op_e'(data[1:0]);
            rca_cfg_io_mux:     m_io_sel[sel][addr]  = io_sel_t'(data);
            rca_cfg_result_mux: m_res_sel[sel][addr] = row_sel_t'(data);
            rca_cfg_io_use:     m_io_use[sel]        = io_use_t'(data);
            default: ;
        endcase
        exp_id.push_back(next_id);
        exp_rd.push_back((k == rca_use) ? grid_ref(sel, ops) : word_vec_t'(0));
        next_id = id_t'(next_id + 1);
    endtask

    task automatic config_set_randomly(input int sel);
        for (int r = 0; r < grid_num_rows; r++) begin
            issue(rca_cfg_row_op, sel, 1'b0, r, cfg_data_t'(random_bits(8)), '0);
        end
        for (int r = 0; r < grid_num_rows; r++) begin
            issue(rca_cfg_io_mux, sel, 1'b0, r, cfg_data_t'(random_bits(8)), '0);
        end
        for (int w = 0; w < num_write_ports; w++) begin
            issue(rca_cfg_result_mux, sel, 1'b0, w, cfg_data_t'(random_bits(8)), '0);
        end
        issue(rca_cfg_io_use, sel, 1'b0, 0, cfg_data_t'(random_bits(8)), '0);
    endtask

    // Nop selects the set and variant shown on the address outputs.
    task automatic check_reg_addrs(input int sel, input logic fb);
        issue(rca_nop, sel, fb, 0, 8'h00, '0);
        idle();
        for (int p = 0; p < num_read_ports; p++) begin
            check_value($sformatf("src_reg_addrs[%0d]", p), 32'(src_reg_addrs[p]),
                        32'(fb ? m_fb[sel][p] : m_nfb[sel][p]));
        end
        for (int p = 0; p < num_write_ports; p++) begin
            check_value($sformatf("dest_reg_addrs[%0d]", p), 32'(dest_reg_addrs[p]),
                32'(fb ? m_fb[sel][num_read_ports + p] : m_nfb[sel][num_read_ports + p]));
        end
    endtask

    // ----------------------------------------
    // Writeback comparison
    // ----------------------------------------
    initial begin : compare_writeback
        logic      stage1;
        logic      stage2;
        id_t       e_id;
        word_vec_t e_rd;
        stage1 = 1'b0;
        stage2 = 1'b0;
        forever begin
            @(posedge clk);
            stage2 = stage1;
            stage1 = new_request && arst_n;   // Sampled by the DUT at this edge.
            @(negedge clk);
            if (stage2) begin
                e_id = exp_id.pop_front();
                e_rd = exp_rd.pop_front();
            end else begin
                e_id = '0;   // Idle writeback reads zero.
                e_rd = '0;
            end
            check_value("wb_done", 32'(wb_done), 32'(stage2));
            check_value("wb_id", 32'(wb_id), 32'(e_id));
            for (int w = 0; w < num_write_ports; w++) begin
                check_value($sformatf("wb_rd[%0d]", w), wb_rd[w], e_rd[w]);
            end
        end
    end

    initial begin : watchdog
        #((total_requests + margin_cycles) * clk_period);
        $display("Timeout: the run did not finish in the expected number of cycles.");
        stop_with_failure();
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin : stimulus
        clk         = 1'b0;
        arst_n      = 1'b0;
        new_request = 1'b0;
        id          = '0;
        kind        = rca_nop;
        rca_sel     = '0;
        use_fb      = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        next_id     = '0;
        lfsr_state  = 32'd91783;
        for (int p = 0; p < num_read_ports; p++) begin
            rs[p] = '0;
        end
        for (int s = 0; s < num_rcas; s++) begin
            for (int a = 0; a < reg_tbl_entries; a++) begin
                m_fb[s][a]  = '0;
                m_nfb[s][a] = '0;
            end
            for (int r = 0; r < grid_num_rows; r++) begin
                m_row_op[s][r] = row_pass;
                m_io_sel[s][r] = '0;
            end
            for (int w = 0; w < num_write_ports; w++) begin
                m_res_sel[s][w] = '0;
            end
            m_io_use[s] = '0;
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_value("wb_done", 32'(wb_done), 32'd0);
        check_value("wb_id", 32'(wb_id), 32'd0);
        for (int p = 0; p < num_read_ports; p++) begin
            check_value($sformatf("wb_rd[%0d]", p), wb_rd[p], 32'd0);
            check_value($sformatf("src_reg_addrs[%0d]", p), 32'(src_reg_addrs[p]), 32'd0);
            check_value($sformatf("dest_reg_addrs[%0d]", p), 32'(dest_reg_addrs[p]), 32'd0);
        end

        // Every kind completes with zeros. Back to back.
        issue(rca_nop, 0, 1'b0, 0, 8'h00, random_ops());
        issue(rca_cfg_fb_reg, 0, 1'b0, 0, cfg_data_t'(random_bits(8)), '0);
        issue(rca_cfg_nfb_reg, 0, 1'b0, 0, cfg_data_t'(random_bits(8)), '0);
        issue(rca_cfg_row_op, 0, 1'b0, 0, cfg_data_t'(random_bits(8)), '0);
        issue(rca_cfg_io_mux, 0, 1'b0, 0, cfg_data_t'(random_bits(8)), '0);
        issue(rca_cfg_result_mux, 0, 1'b0, 0, cfg_data_t'(random_bits(8)), '0);
        issue(rca_cfg_io_use, 0, 1'b0, 0, cfg_data_t'(random_bits(8)), '0);
        idle();

        // Set 1 writes between uses of set 0.
        for (int n = 0; n < num_rounds; n++) begin
            config_set_randomly(0);
            repeat (4) issue(rca_use, 0, 1'b0, 0, 8'h00, random_ops());
            config_set_randomly(1);
            repeat (2) issue(rca_use, 0, 1'b0, 0, 8'h00, random_ops());
            repeat (2) issue(rca_use, 1, 1'b0, 0, 8'h00, random_ops());
        end
        idle();

        for (int s = 0; s < num_rcas; s++) begin
            for (int a = 0; a < reg_tbl_entries; a++) begin
                issue(rca_cfg_fb_reg, s, 1'b0, a, cfg_data_t'(random_bits(8)), '0);
                issue(rca_cfg_nfb_reg, s, 1'b0, a, cfg_data_t'(random_bits(8)), '0);
            end
        end
        for (int s = 0; s < num_rcas; s++) begin
            for (int f = 0; f < 2; f++) begin
                check_reg_addrs(s, f[0]);
            end
        end

        repeat (4) idle();   // Drain writeback.
        if (exp_id.size() != 0) begin
            $display("%0d expected completions never appeared on writeback.", exp_id.size());
            stop_with_failure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== rtl/rca_unit.sv ====
`timescale 1ns/100ps

module rca_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    // Issue side.
    input  logic                   new_request,
    input  rca_op_pkg::id_t        id,
    input  rca_op_pkg::rca_instr_e kind,
    input  rca_cfg_pkg::rca_sel_t  rca_sel,
    input  logic                   use_fb,
    input  rca_op_pkg::cfg_addr_t  cfg_addr,
    input  rca_op_pkg::cfg_data_t  cfg_data,
    input  rca_op_pkg::operand_t   rs             [rca_cfg_pkg::num_read_ports],
    // Writeback side.
    output logic                   wb_done,
    output rca_op_pkg::id_t        wb_id,
    output rca_op_pkg::operand_t   wb_rd          [rca_cfg_pkg::num_write_ports],
    // Operand fetch addresses for the core.
    output rca_op_pkg::reg_addr_t  src_reg_addrs  [rca_cfg_pkg::num_read_ports],
    output rca_op_pkg::reg_addr_t  dest_reg_addrs [rca_cfg_pkg::num_write_ports]
);
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;

    logic      req_valid;
    id_t       req_id;
    logic      use_valid;
    rca_sel_t  req_rca_sel;
    logic      req_use_fb;
    cfg_addr_t req_cfg_addr;
    cfg_data_t req_cfg_data;
    operand_t  req_rs [num_read_ports];

    logic fb_reg_wr_en;
    logic nfb_reg_wr_en;
    logic row_op_wr_en;
    logic io_mux_wr_en;
    logic result_mux_wr_en;
    logic io_use_wr_en;

    row_op_e  row_ops     [grid_num_rows];
    io_sel_t  io_sels     [grid_num_rows];
    row_sel_t result_sels [num_write_ports];
    io_use_t  io_use;
    operand_t grid_rd     [num_write_ports];

    rca_issue_decode u_issue_decode (
        .clk(clk), .arst_n(arst_n), .new_request(new_request), .id(id), .kind(kind),
        .rca_sel(rca_sel), .use_fb(use_fb), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .rs(rs), .req_valid(req_valid), .req_id(req_id), .use_valid(use_valid),
        .req_rca_sel(req_rca_sel), .req_use_fb(req_use_fb), .req_cfg_addr(req_cfg_addr),
        .req_cfg_data(req_cfg_data), .req_rs(req_rs),
        .fb_reg_wr_en(fb_reg_wr_en), .nfb_reg_wr_en(nfb_reg_wr_en),
        .row_op_wr_en(row_op_wr_en), .io_mux_wr_en(io_mux_wr_en),
        .result_mux_wr_en(result_mux_wr_en), .io_use_wr_en(io_use_wr_en)
    );

    // Tables see the registered request.
    rca_config_regs u_config_regs (
        .clk(clk), .arst_n(arst_n), .rca_sel(req_rca_sel), .use_fb(req_use_fb),
        .cfg_addr(req_cfg_addr), .cfg_data(req_cfg_data),
        .fb_reg_wr_en(fb_reg_wr_en), .nfb_reg_wr_en(nfb_reg_wr_en),
        .row_op_wr_en(row_op_wr_en), .io_mux_wr_en(io_mux_wr_en),
        .result_mux_wr_en(result_mux_wr_en), .io_use_wr_en(io_use_wr_en),
        .src_reg_addrs(src_reg_addrs), .dest_reg_addrs(dest_reg_addrs),
        .row_ops(row_ops), .io_sels(io_sels), .result_sels(result_sels), .io_use(io_use)
    );

    rca_grid u_grid (
        .rs(req_rs), .row_ops(row_ops), .io_sels(io_sels), .io_use(io_use),
        .result_sels(result_sels), .rd(grid_rd)
    );

    rca_writeback u_writeback (
        .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req_id(req_id),
        .use_valid(use_valid), .grid_rd(grid_rd),
        .wb_done(wb_done), .wb_id(wb_id), .wb_rd(wb_rd)
    );

endmodule

// ==== rtl/rca_writeback.sv ====
`timescale 1ns/100ps

module rca_writeback (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 req_valid,
    input  rca_op_pkg::id_t      req_id,
    input  logic                 use_valid,
    input  rca_op_pkg::operand_t grid_rd [rca_cfg_pkg::num_write_ports],
    output logic                 wb_done,
    output rca_op_pkg::id_t      wb_id,
    output rca_op_pkg::operand_t wb_rd   [rca_cfg_pkg::num_write_ports]
);
    import rca_cfg_pkg::*;

    // One completion per registered request, no back-pressure.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_done <= 1'b0;
            wb_id   <= '0;
            for (int w = 0; w < num_write_ports; w++) begin
                wb_rd[w] <= '0;
            end
        end else begin
            wb_done <= req_valid;
            wb_id   <= req_valid ? req_id : '0;   // Zero when idle.
            for (int w = 0; w < num_write_ports; w++) begin
                // Config and nop complete with zeros.
                wb_rd[w] <= use_valid ? grid_rd[w] : '0;
            end
        end
    end

    // A use only ever rides on a valid request.
    a_use_has_valid : assert property (@(posedge clk) disable iff (!arst_n)
        use_valid |-> req_valid);

endmodule

// ==== rtl/rca_grid.sv ====
`timescale 1ns/100ps

module rca_grid (
    input  rca_op_pkg::operand_t  rs          [rca_cfg_pkg::num_read_ports],
    input  rca_cfg_pkg::row_op_e  row_ops     [rca_cfg_pkg::grid_num_rows],
    input  rca_cfg_pkg::io_sel_t  io_sels     [rca_cfg_pkg::grid_num_rows],
    input  rca_cfg_pkg::io_use_t  io_use,
    input  rca_cfg_pkg::row_sel_t result_sels [rca_cfg_pkg::num_write_ports],
    output rca_op_pkg::operand_t  rd          [rca_cfg_pkg::num_write_ports]
);
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;

    operand_t row_val [grid_num_rows];

    function automatic operand_t row_apply(
        input row_op_e  op,
        input operand_t prev,
        input operand_t opnd
    );
        operand_t res;
        case (op)
            row_pass: res = opnd;
            row_add:  res = prev + opnd;
            row_xor:  res = prev ^ opnd;
            row_sub:  res = prev - opnd;
            default:  res = '0;
        endcase
        return res;
    endfunction

    // ----------------------------------------
    // Row chain
    // ----------------------------------------
    for (genvar r = 0; r < grid_num_rows; r++) begin : g_row
        operand_t prev_val;
        operand_t opnd;

        if (r == 0) begin : g_first
            assign prev_val = '0;
        end else begin : g_chain
            assign prev_val = row_val[r-1];
        end

        // Unused row or select past the last port reads zero.
        assign opnd = (io_use[r] && (io_sels[r] < num_read_ports)) ? rs[io_sels[r]] : '0;
        assign row_val[r] = row_apply(row_ops[r], prev_val, opnd);
    end

    // ----------------------------------------
    // Result mux
    // ----------------------------------------
    always_comb begin
        for (int w = 0; w < num_write_ports; w++) begin
            rd[w] = row_val[result_sels[w]];
        end
    end

endmodule

// ==== rtl/rca_issue_decode.sv ====
`timescale 1ns/100ps

module rca_issue_decode (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   new_request,
    input  rca_op_pkg::id_t        id,
    input  rca_op_pkg::rca_instr_e kind,
    input  rca_cfg_pkg::rca_sel_t  rca_sel,
    input  logic                   use_fb,
    input  rca_op_pkg::cfg_addr_t  cfg_addr,
    input  rca_op_pkg::cfg_data_t  cfg_data,
    input  rca_op_pkg::operand_t   rs [rca_cfg_pkg::num_read_ports],
    output logic                   req_valid,
    output rca_op_pkg::id_t        req_id,
    output logic                   use_valid,
    output rca_cfg_pkg::rca_sel_t  req_rca_sel,
    output logic                   req_use_fb,
    output rca_op_pkg::cfg_addr_t  req_cfg_addr,
    output rca_op_pkg::cfg_data_t  req_cfg_data,
    output rca_op_pkg::operand_t   req_rs [rca_cfg_pkg::num_read_ports],
    output logic                   fb_reg_wr_en,
    output logic                   nfb_reg_wr_en,
    output logic                   row_op_wr_en,
    output logic                   io_mux_wr_en,
    output logic                   result_mux_wr_en,
    output logic                   io_use_wr_en
);
    import rca_op_pkg::*;

    rca_instr_e req_kind;

    // Set select and variant feed the register-address outputs directly.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_valid   <= 1'b0;
            req_kind    <= rca_nop;
            req_rca_sel <= '0;
            req_use_fb  <= 1'b0;
        end else begin
            req_valid <= new_request;
            if (new_request) begin
                req_kind    <= kind;
                req_rca_sel <= rca_sel;
                req_use_fb  <= use_fb;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_request) begin
            req_id       <= id;
            req_cfg_addr <= cfg_addr;
            req_cfg_data <= cfg_data;
            req_rs       <= rs;
        end
    end

    // Decode after the register. Nop raises nothing here.
    assign fb_reg_wr_en     = req_valid && (req_kind == rca_cfg_fb_reg);
    assign nfb_reg_wr_en    = req_valid && (req_kind == rca_cfg_nfb_reg);
    assign row_op_wr_en     = req_valid && (req_kind == rca_cfg_row_op);
    assign io_mux_wr_en     = req_valid && (req_kind == rca_cfg_io_mux);
    assign result_mux_wr_en = req_valid && (req_kind == rca_cfg_result_mux);
    assign io_use_wr_en     = req_valid && (req_kind == rca_cfg_io_use);
    assign use_valid        = req_valid && (req_kind == rca_use);

    a_kind_known : assert property (@(posedge clk) disable iff (!arst_n)
        new_request |-> !$isunknown(kind));

endmodule

// ==== rca_config/rca_config_regs.sv ====
`timescale 1ns/100ps

module rca_config_regs (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rca_cfg_pkg::rca_sel_t  rca_sel,
    input  logic                   use_fb,
    input  rca_op_pkg::cfg_addr_t  cfg_addr,
    input  rca_op_pkg::cfg_data_t  cfg_data,
    input  logic                   fb_reg_wr_en,
    input  logic                   nfb_reg_wr_en,
    input  logic                   row_op_wr_en,
    input  logic                   io_mux_wr_en,
    input  logic                   result_mux_wr_en,
    input  logic                   io_use_wr_en,
    output rca_op_pkg::reg_addr_t  src_reg_addrs  [rca_cfg_pkg::num_read_ports],
    output rca_op_pkg::reg_addr_t  dest_reg_addrs [rca_cfg_pkg::num_write_ports],
    output rca_cfg_pkg::row_op_e   row_ops        [rca_cfg_pkg::grid_num_rows],
    output rca_cfg_pkg::io_sel_t   io_sels        [rca_cfg_pkg::grid_num_rows],
    output rca_cfg_pkg::row_sel_t  result_sels    [rca_cfg_pkg::num_write_ports],
    output rca_cfg_pkg::io_use_t   io_use
);
    import rca_cfg_pkg::*;
    import rca_op_pkg::*;

    typedef logic [$clog2(reg_tbl_depth)-1:0] reg_idx_t;
    typedef logic [$clog2(row_tbl_depth)-1:0] row_idx_t;
    typedef logic [$clog2(res_tbl_depth)-1:0] res_idx_t;

    reg_idx_t  reg_wr_addr;
    row_idx_t  row_wr_addr;
    res_idx_t  res_wr_addr;

    reg_addr_t fb_regs    [reg_tbl_depth];
    reg_addr_t nfb_regs   [reg_tbl_depth];
    row_op_e   row_op_tbl [row_tbl_depth];
    io_sel_t   io_mux_tbl [row_tbl_depth];
    row_sel_t  res_tbl    [res_tbl_depth];
    io_use_t   io_use_tbl [use_tbl_depth];

    // Set base plus field index.
    assign reg_wr_addr = reg_idx_t'(rca_sel * reg_tbl_entries + cfg_addr);
    assign row_wr_addr = row_idx_t'(rca_sel * grid_num_rows + cfg_addr);
    assign res_wr_addr = res_idx_t'(rca_sel * num_write_ports + cfg_addr);

    // ----------------------------------------
    // Banks
    // ----------------------------------------
    cfg_bank #(.entry_t(reg_addr_t), .depth(reg_tbl_depth)) u_fb_regs (
        .clk(clk), .arst_n(arst_n), .wr_en(fb_reg_wr_en), .wr_addr(reg_wr_addr),
        .wr_data(reg_addr_t'(cfg_data)), .entries(fb_regs)
    );
    cfg_bank #(.entry_t(reg_addr_t), .depth(reg_tbl_depth)) u_nfb_regs (
        .clk(clk), .arst_n(arst_n), .wr_en(nfb_reg_wr_en), .wr_addr(reg_wr_addr),
        .wr_data(reg_addr_t'(cfg_data)), .entries(nfb_regs)
    );
    cfg_bank #(.entry_t(row_op_e), .depth(row_tbl_depth)) u_row_ops (
        .clk(clk), .arst_n(arst_n), .wr_en(row_op_wr_en), .wr_addr(row_wr_addr),
        .wr_data(row_op_e'(cfg_data[1:0])), .entries(row_op_tbl)
    );
    cfg_bank #(.entry_t(io_sel_t), .depth(row_tbl_depth)) u_io_mux (
        .clk(clk), .arst_n(arst_n), .wr_en(io_mux_wr_en), .wr_addr(row_wr_addr),
        .wr_data(io_sel_t'(cfg_data)), .entries(io_mux_tbl)
    );
    cfg_bank #(.entry_t(row_sel_t), .depth(res_tbl_depth)) u_result_mux (
        .clk(clk), .arst_n(arst_n), .wr_en(result_mux_wr_en), .wr_addr(res_wr_addr),
        .wr_data(row_sel_t'(cfg_data)), .entries(res_tbl)
    );
    cfg_bank #(.entry_t(io_use_t), .depth(use_tbl_depth)) u_io_use (
        .clk(clk), .arst_n(arst_n), .wr_en(io_use_wr_en), .wr_addr(rca_sel),
        .wr_data(io_use_t'(cfg_data)), .entries(io_use_tbl)
    );

    // ----------------------------------------
    // Current set view
    // ----------------------------------------
    always_comb begin
        for (int p = 0; p < num_read_ports; p++) begin
            src_reg_addrs[p] = use_fb ? fb_regs[rca_sel * reg_tbl_entries + p]
                                      : nfb_regs[rca_sel * reg_tbl_entries + p];
        end
        // Destinations sit after the source ports.
        for (int p = 0; p < num_write_ports; p++) begin
            dest_reg_addrs[p] = use_fb
                ? fb_regs[rca_sel * reg_tbl_entries + num_read_ports + p]
                : nfb_regs[rca_sel * reg_tbl_entries + num_read_ports + p];
        end
        for (int r = 0; r < grid_num_rows; r++) begin
            row_ops[r] = row_op_tbl[rca_sel * grid_num_rows + r];
            io_sels[r] = io_mux_tbl[rca_sel * grid_num_rows + r];
        end
        for (int w = 0; w < num_write_ports; w++) begin
            result_sels[w] = res_tbl[rca_sel * num_write_ports + w];
        end
        io_use = io_use_tbl[rca_sel];
    end

    // Field index must not spill into the next set.
    a_row_field : assert property (@(posedge clk) disable iff (!arst_n)
        (row_op_wr_en || io_mux_wr_en) |-> (cfg_addr < grid_num_rows));
    a_port_field : assert property (@(posedge clk) disable iff (!arst_n)
        result_mux_wr_en |-> (cfg_addr < num_write_ports));
    a_reg_field : assert property (@(posedge clk) disable iff (!arst_n)
        (fb_reg_wr_en || nfb_reg_wr_en) |-> (cfg_addr < reg_tbl_entries));

endmodule

// ==== rca_config/cfg_bank.sv ====
`timescale 1ns/100ps

module cfg_bank #(
    parameter type entry_t = logic,
    parameter int  depth   = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  entry_t                   wr_data,
    output entry_t                   entries [depth]
);

    // One entry written per enabled edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                entries[i] <= entry_t'(0);
            end
        end else if (wr_en) begin
            entries[wr_addr] <= wr_data;
        end
    end

    // Address computed upstream must land inside this bank.
    a_wr_addr_in_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_en |-> (wr_addr < depth)
    );

endmodule

// ==== common/rca_op_pkg.sv ====
package rca_op_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] operand_t;
    typedef logic [2:0]      id_t;
    typedef logic [4:0]      reg_addr_t;

    // ----------------------------------------
    // Instruction kinds from the issue stage
    // ----------------------------------------
    typedef enum logic [2:0] {
        rca_nop            = 3'd0,
        rca_cfg_fb_reg     = 3'd1,
        rca_cfg_nfb_reg    = 3'd2,
        rca_cfg_row_op     = 3'd3,
        rca_cfg_io_mux     = 3'd4,
        rca_cfg_result_mux = 3'd5,
        rca_cfg_io_use     = 3'd6,
        rca_use            = 3'd7
    } rca_instr_e;

    // Field index within a table.
    // Register tables: 0..4 source ports, 5..9 destination ports.
    typedef logic [3:0] cfg_addr_t;

    // Each table keeps only its low bits.
    typedef logic [7:0] cfg_data_t;

endpackage

// ==== common/rca_cfg_pkg.sv ====
package rca_cfg_pkg;

    // ----------------------------------------
    // Grid geometry
    // ----------------------------------------
    localparam int num_rcas        = 2;
    localparam int grid_num_rows   = 4;
    localparam int num_read_ports  = 5;
    localparam int num_write_ports = 5;

    // Register table holds source ports, then destination ports.
    localparam int reg_tbl_entries = num_read_ports + num_write_ports;

    // Bank depths over all configuration sets.
    localparam int reg_tbl_depth = num_rcas * reg_tbl_entries;
    localparam int row_tbl_depth = num_rcas * grid_num_rows;
    localparam int res_tbl_depth = num_rcas * num_write_ports;
    localparam int use_tbl_depth = num_rcas;

    typedef logic [$clog2(num_rcas)-1:0] rca_sel_t;

    // ----------------------------------------
    // Table entry types
    // ----------------------------------------
    // Row combines its operand with the previous row value.
    typedef enum logic [1:0] {
        row_pass = 2'd0,
        row_add  = 2'd1,
        row_xor  = 2'd2,
        row_sub  = 2'd3
    } row_op_e;

    typedef logic [2:0] io_sel_t;    // Operand index.
    typedef logic [1:0] row_sel_t;   // Row index for results.

    // One bit per row.
    typedef logic [grid_num_rows-1:0] io_use_t;

endpackage
